// File: project.f
src/bp_pkg.sv
src/bp_history.sv
src/counter_table.sv
src/chooser.sv
src/tournament_predictor.sv
test/tb_predictor_asserts.sv
test/tb_tournament_predictor.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the predictor testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
	--timescale 1ns/10ps \
	--top-module tb_tournament_predictor \
	-f project.f \
	-o tb_tournament_predictor

status=0
sim_out=$(./obj_dir/tb_tournament_predictor 2>&1) || status=$?
printf '%s\n' "$sim_out"

if [ "$status" -eq 0 ] && grep -qx "PASS: all tests" <<< "$sim_out"; then
	echo "simulation passed"
	exit 0
fi

echo "simulation failed"
exit 1

// File: src/bp_history.sv
`timescale 1ns/10ps

module bp_history (
	input  logic             clk,
	input  logic             rst_n,
	input  bp_pkg::pc_t      lookup_pc,
	input  logic             update_valid,
	input  bp_pkg::pc_t      update_pc,
	input  bp_pkg::ghr_t     update_ghr,
	input  logic             update_taken,
	output bp_pkg::tbl_idx_t rd_idx [bp_pkg::NUM_TABLES],
	output bp_pkg::tbl_idx_t wr_idx [bp_pkg::NUM_TABLES],
	output bp_pkg::ghr_t     ghr_now
);
import bp_pkg::*;

ghr_t     ghr;
ghr_t     ghr_next;
tbl_idx_t rd_base;
tbl_idx_t wr_base;

// resolved outcome enters at bit 0
assign ghr_next = {ghr[GHR_BITS-2:0], update_taken};

always_ff @(posedge clk) begin
	if (!rst_n) begin
		ghr <= '0;
	end else if (update_valid) begin
		ghr <= ghr_next;
	end
end

assign ghr_now = ghr;

assign rd_base = pc_index(lookup_pc);
assign wr_base = pc_index(update_pc);

// lookups hash with the live history
always_comb begin
	rd_idx[table_local] = rd_base;
	rd_idx[table_gshare] = rd_base ^ ghr;
end

// updates hash with the history the lookup saw,
// returned by the caller with the outcome
always_comb begin
	wr_idx[table_local] = wr_base;
	wr_idx[table_gshare] = wr_base ^ update_ghr;
end

endmodule : bp_history

// File: src/bp_pkg.sv
package bp_pkg;

localparam int PC_BITS = 32;
localparam int IDX_BITS = 10;
// history width must equal the index width for the xor hash
localparam int GHR_BITS = IDX_BITS;
// drop the byte offset of a word-aligned pc
localparam int IDX_LSB = 2;
localparam int NUM_TABLES = 2;
localparam int TABLE_ENTRIES = 2 ** IDX_BITS;

typedef logic [PC_BITS-1:0] pc_t;
typedef logic [IDX_BITS-1:0] tbl_idx_t;
typedef logic [GHR_BITS-1:0] ghr_t;

// upper bit is the taken prediction
typedef enum logic [1:0] {
	strong_not_taken = 2'b00,
	weak_not_taken   = 2'b01,
	weak_taken       = 2'b10,
	strong_taken     = 2'b11
} ctr_state_e;

// table names, also the slot order of the counter tables
typedef enum logic [0:0] {
	table_local  = 1'b0,
	table_gshare = 1'b1
} table_sel_e;

localparam ctr_state_e CTR_INIT = weak_not_taken;

function automatic tbl_idx_t pc_index(input pc_t pc);
	return pc[IDX_LSB +: IDX_BITS];
endfunction

function automatic logic ctr_taken(input ctr_state_e state);
	return state[1];
endfunction

// one saturating step toward up (taken) or down (not taken)
function automatic ctr_state_e ctr_step(input ctr_state_e cur, input logic up);
	ctr_state_e nxt;
	case (cur)
		strong_not_taken: nxt = up ? weak_not_taken : strong_not_taken;
		weak_not_taken:   nxt = up ? weak_taken : strong_not_taken;
		weak_taken:       nxt = up ? strong_taken : weak_not_taken;
		default:          nxt = up ? strong_taken : weak_taken;
	endcase
	return nxt;
endfunction

endpackage : bp_pkg

// File: src/chooser.sv
`timescale 1ns/10ps

module chooser (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            lookup_valid,
	input  bp_pkg::pc_t                     lookup_pc,
	input  bp_pkg::ghr_t                    ghr_now,
	input  logic [bp_pkg::NUM_TABLES-1:0]   rd_taken,
	input  logic                            update_valid,
	input  bp_pkg::pc_t                     update_pc,
	input  logic                            update_taken,
	input  logic [bp_pkg::NUM_TABLES-1:0]   wr_taken,
	output logic                            pred_valid,
	output logic                            pred_taken,
	output bp_pkg::table_sel_e              pred_table,
	output bp_pkg::ghr_t                    pred_ghr
);
import bp_pkg::*;

// upper bit set means trust gshare
ctr_state_e sel_ctr [TABLE_ENTRIES];

tbl_idx_t   lk_idx;
ctr_state_e lk_state;
table_sel_e lk_table;
logic       lk_taken;

tbl_idx_t   up_idx;
ctr_state_e up_state;
logic       local_right;
logic       gshare_right;
logic       train;

// lookup side
assign lk_idx = pc_index(lookup_pc);
assign lk_state = sel_ctr[lk_idx];
assign lk_table = ctr_taken(lk_state) ? table_gshare : table_local;
assign lk_taken = rd_taken[lk_table];

// update side
assign up_idx = pc_index(update_pc);
assign up_state = sel_ctr[up_idx];
assign local_right = (wr_taken[table_local] == update_taken);
assign gshare_right = (wr_taken[table_gshare] == update_taken);

// only train when exactly one table got it right
assign train = update_valid && (local_right != gshare_right);

always_ff @(posedge clk) begin
	if (!rst_n) begin
		for (int i = 0; i < TABLE_ENTRIES; i++) begin
			sel_ctr[i] <= CTR_INIT;
		end
	end else if (train) begin
		// step toward gshare if it was the right one
		sel_ctr[up_idx] <= ctr_step(up_state, gshare_right);
	end
end

// single output stage, answers every lookup
always_ff @(posedge clk) begin
	if (!rst_n) begin
		pred_valid <= 1'b0;
		pred_taken <= 1'b0;
		pred_table <= table_local;
		pred_ghr <= '0;
	end else begin
		pred_valid <= lookup_valid;
		if (lookup_valid) begin
			pred_taken <= lk_taken;
			pred_table <= lk_table;
			// history used for the gshare read this cycle
			pred_ghr <= ghr_now;
		end
	end
end

endmodule : chooser

// File: src/counter_table.sv
`timescale 1ns/10ps

module counter_table (
	input  logic             clk,
	input  logic             rst_n,
	input  bp_pkg::tbl_idx_t rd_idx,
	input  bp_pkg::tbl_idx_t wr_idx,
	input  logic             update_valid,
	input  logic             update_taken,
	output logic             rd_taken,
	output logic             wr_taken
);
import bp_pkg::*;

ctr_state_e ctr [TABLE_ENTRIES];

ctr_state_e rd_state;
ctr_state_e wr_state;
ctr_state_e wr_next;

// read port for the lookup
assign rd_state = ctr[rd_idx];
assign rd_taken = ctr_taken(rd_state);

// update port sees the entry before the write lands
assign wr_state = ctr[wr_idx];
assign wr_taken = ctr_taken(wr_state);

assign wr_next = ctr_step(wr_state, update_taken);

always_ff @(posedge clk) begin
	if (!rst_n) begin
		for (int i = 0; i < TABLE_ENTRIES; i++) begin
			ctr[i] <= CTR_INIT;
		end
	end else if (update_valid) begin
		ctr[wr_idx] <= wr_next;
	end
end

endmodule : counter_table

// File: src/tournament_predictor.sv
`timescale 1ns/10ps

module tournament_predictor (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               lookup_valid,
	input  bp_pkg::pc_t        lookup_pc,
	input  logic               update_valid,
	input  bp_pkg::pc_t        update_pc,
	input  bp_pkg::ghr_t       update_ghr,
	input  logic               update_taken,
	output logic               pred_valid,
	output logic               pred_taken,
	output bp_pkg::table_sel_e pred_table,
	output bp_pkg::ghr_t       pred_ghr
);
import bp_pkg::*;

tbl_idx_t rd_idx [NUM_TABLES];
tbl_idx_t wr_idx [NUM_TABLES];
ghr_t     ghr_now;

logic [NUM_TABLES-1:0] rd_taken;
logic [NUM_TABLES-1:0] wr_taken;

bp_history i_history (
	.clk          (clk),
	.rst_n        (rst_n),
	.lookup_pc    (lookup_pc),
	.update_valid (update_valid),
	.update_pc    (update_pc),
	.update_ghr   (update_ghr),
	.update_taken (update_taken),
	.rd_idx       (rd_idx),
	.wr_idx       (wr_idx),
	.ghr_now      (ghr_now)
);

// slot t follows table_sel_e, 0 local and 1 gshare
generate
	for (genvar t = 0; t < NUM_TABLES; t++) begin : g_table
		counter_table i_table (
			.clk          (clk),
			.rst_n        (rst_n),
			.rd_idx       (rd_idx[t]),
			.wr_idx       (wr_idx[t]),
			.update_valid (update_valid),
			.update_taken (update_taken),
			.rd_taken     (rd_taken[t]),
			.wr_taken     (wr_taken[t])
		);
	end
endgenerate

chooser i_chooser (
	.clk          (clk),
	.rst_n        (rst_n),
	.lookup_valid (lookup_valid),
	.lookup_pc    (lookup_pc),
	.ghr_now      (ghr_now),
	.rd_taken     (rd_taken),
	.update_valid (update_valid),
	.update_pc    (update_pc),
	.update_taken (update_taken),
	.wr_taken     (wr_taken),
	.pred_valid   (pred_valid),
	.pred_taken   (pred_taken),
	.pred_table   (pred_table),
	.pred_ghr     (pred_ghr)
);

endmodule : tournament_predictor

// File: test/tb_predictor_asserts.sv
`timescale 1ns/10ps

module tb_predictor_asserts (
	input logic               clk,
	input logic               rst_n,
	input logic               lookup_valid,
	input logic               pred_valid,
	input logic               pred_taken,
	input bp_pkg::table_sel_e pred_table,
	input bp_pkg::ghr_t       pred_ghr
);

// one cycle latency while running
a_latency : assert property (@(posedge clk)
	($past(rst_n) === 1'b1) |-> (pred_valid == $past(lookup_valid)))
	else $error("pred_valid does not follow lookup_valid by one cycle");

// output stage cleared by reset
a_reset_idle : assert property (@(posedge clk)
	(($past(rst_n) === 1'b0) && rst_n) |-> !pred_valid)
	else $error("pred_valid high in the cycle after reset");

a_known : assert property (@(posedge clk)
	pred_valid |-> !$isunknown({pred_taken, pred_table, pred_ghr}))
	else $error("prediction fields unknown while pred_valid is high");

endmodule : tb_predictor_asserts

// File: test/tb_tournament_predictor.sv
`timescale 1ns/10ps

module tb_tournament_predictor;
import bp_pkg::*;

localparam int POOL_SIZE = 16;
localparam int WAIT_LIMIT = 8;
localparam int RANDOM_CYCLES = 2000;

logic       clk;
logic       rst_n;
logic       lookup_valid;
pc_t        lookup_pc;
logic       update_valid;
pc_t        update_pc;
ghr_t       update_ghr;
logic       update_taken;
logic       pred_valid;
logic       pred_taken;
table_sel_e pred_table;
ghr_t       pred_ghr;

// reference model state
ctr_state_e m_local [TABLE_ENTRIES];
ctr_state_e m_gshare [TABLE_ENTRIES];
ctr_state_e m_sel [TABLE_ENTRIES];
ghr_t       m_ghr;

// prediction expected in the next cycle
logic       exp_valid;
logic       exp_taken;
table_sel_e exp_table;
ghr_t       exp_ghr;
int         exp_sel;

// answered lookups still waiting for an outcome
int   pend_sel [$];
ghr_t pend_ghr [$];

logic [15:0] lfsr;
logic        got_pred;

tournament_predictor i_dut (
	.clk          (clk),
	.rst_n        (rst_n),
	.lookup_valid (lookup_valid),
	.lookup_pc    (lookup_pc),
	.update_valid (update_valid),
	.update_pc    (update_pc),
	.update_ghr   (update_ghr),
	.update_taken (update_taken),
	.pred_valid   (pred_valid),
	.pred_taken   (pred_taken),
	.pred_table   (pred_table),
	.pred_ghr     (pred_ghr)
);

bind tournament_predictor tb_predictor_asserts i_asserts (
	.clk          (clk),
	.rst_n        (rst_n),
	.lookup_valid (lookup_valid),
	.pred_valid   (pred_valid),
	.pred_taken   (pred_taken),
	.pred_table   (pred_table),
	.pred_ghr     (pred_ghr)
);

always #4 clk = ~clk;

// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	logic fb;
	fb = s[15] ^ s[13] ^ s[12] ^ s[10];
	return {s[14:0], fb};
endfunction

task automatic draw_bits(input int n, output logic [31:0] v);
	v = '0;
	for (int i = 0; i < n; i++) begin
		lfsr = lfsr_next(lfsr);
		v = {v[30:0], lfsr[0]};
	end
endtask

// word aligned pcs that each land on their own table index
function automatic pc_t pool_pc(input int sel);
	return pc_t'(32'h0040_0000 + sel * 32'h0000_0104);
endfunction

function automatic logic bias_outcome(input int sel);
	return (sel % 3) != 0;
endfunction

function automatic tbl_idx_t model_index(input pc_t pc);
	return pc[IDX_LSB +: IDX_BITS];
endfunction

function automatic ctr_state_e model_step(input ctr_state_e cur, input logic up);
	logic [1:0] v;
	v = cur;
	if (up && v != 2'b11) begin
		v = v + 2'd1;
	end else if (!up && v != 2'b00) begin
		v = v - 2'd1;
	end
	return ctr_state_e'(v);
endfunction

task automatic model_reset();
	for (int i = 0; i < TABLE_ENTRIES; i++) begin
		m_local[i] = weak_not_taken;
		m_gshare[i] = weak_not_taken;
		m_sel[i] = weak_not_taken;
	end
	m_ghr = '0;
endtask

task automatic model_update(input pc_t pc, input ghr_t ughr, input logic t);
	tbl_idx_t li;
	tbl_idx_t gi;
	logic     local_ok;
	logic     gshare_ok;
	li = model_index(pc);
	gi = li ^ ughr;
	local_ok = (m_local[li][1] == t);
	gshare_ok = (m_gshare[gi][1] == t);
	// chooser only moves when one table was right
	if (local_ok != gshare_ok) begin
		m_sel[li] = model_step(m_sel[li], gshare_ok);
	end
	m_local[li] = model_step(m_local[li], t);
	m_gshare[gi] = model_step(m_gshare[gi], t);
	m_ghr = {m_ghr[GHR_BITS-2:0], t};
endtask

task automatic stop_on_error();
	$display("FAIL: see errors above");
	$fatal(1, "stopping after the first error");
endtask

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
	assert (got === exp) else begin
		$display("FAILED time=%0t %s expected=%0h actual=%0h", $time, name, exp, got);
		stop_on_error();
	end
endtask

task automatic run_cycle(input logic lv, input int lsel, input logic uv, input int usel,
		input ghr_t ughr, input logic ut);
	tbl_idx_t li;
	logic     use_g;
	@(posedge clk);
	lookup_valid <= lv;
	lookup_pc <= pool_pc(lsel);
	update_valid <= uv;
	update_pc <= pool_pc(usel);
	update_ghr <= ughr;
	update_taken <= ut;
	@(negedge clk);
	// outputs now answer the lookup of the previous cycle
	check_value("pred_valid", 32'(exp_valid), 32'(pred_valid));
	if (exp_valid) begin
		check_value("pred_taken", 32'(exp_taken), 32'(pred_taken));
		check_value("pred_table", 32'(exp_table), 32'(pred_table));
		check_value("pred_ghr", 32'(exp_ghr), 32'(pred_ghr));
		pend_sel.push_back(exp_sel);
		pend_ghr.push_back(pred_ghr);
		got_pred = 1'b1;
	end
	// this lookup sees the state before the coming edge
	exp_valid = lv;
	if (lv) begin
		li = model_index(pool_pc(lsel));
		use_g = m_sel[li][1];
		exp_table = use_g ? table_gshare : table_local;
		exp_taken = use_g ? m_gshare[li ^ m_ghr][1] : m_local[li][1];
		exp_ghr = m_ghr;
		exp_sel = lsel;
	end
	if (uv) begin
		model_update(pool_pc(usel), ughr, ut);
	end
endtask

task automatic lookup_and_wait(input int sel);
	int tries;
	tries = 0;
	run_cycle(1'b1, sel, 1'b0, 0, '0, 1'b0);
	got_pred = 1'b0;
	while (!got_pred) begin
		if (tries == WAIT_LIMIT) begin
			$display("timeout: no prediction came back for pool entry %0d", sel);
			stop_on_error();
		end
		run_cycle(1'b0, sel, 1'b0, 0, '0, 1'b0);
		tries++;
	end
endtask

// update as if the caller returned the history it saw
task automatic update_now(input int sel, input logic t);
	run_cycle(1'b0, 0, 1'b1, sel, m_ghr, t);
endtask

task automatic check_first_lookup();
	lookup_and_wait(0);
	check_value("pred_taken", 32'd0, 32'(pred_taken));
	check_value("pred_table", 32'(table_local), 32'(pred_table));
	check_value("pred_ghr", 32'd0, 32'(pred_ghr));
	lookup_and_wait(1);
endtask

task automatic check_back_to_back();
	for (int i = 0; i < 6; i++) begin
		run_cycle(1'b1, i, 1'b0, 0, '0, 1'b0);
	end
	run_cycle(1'b0, 0, 1'b0, 0, '0, 1'b0);
	run_cycle(1'b1, 7, 1'b0, 0, '0, 1'b0);
	run_cycle(1'b0, 0, 1'b0, 0, '0, 1'b0);
	run_cycle(1'b1, 8, 1'b0, 0, '0, 1'b0);
	run_cycle(1'b1, 9, 1'b0, 0, '0, 1'b0);
	run_cycle(1'b0, 0, 1'b0, 0, '0, 1'b0);
endtask

task automatic check_saturation();
	update_now(3, 1'b1);
	update_now(3, 1'b1);
	lookup_and_wait(3);
	check_value("pred_taken", 32'd1, 32'(pred_taken));
	update_now(3, 1'b1);
	update_now(3, 1'b1);
	lookup_and_wait(3);
	check_value("pred_taken", 32'd1, 32'(pred_taken));
	update_now(3, 1'b0);
	update_now(3, 1'b0);
	lookup_and_wait(3);
	check_value("pred_taken", 32'd0, 32'(pred_taken));
endtask

// alternating outcome defeats the local table but not gshare
task automatic check_alternating();
	logic t;
	for (int i = 0; i < 40; i++) begin
		lookup_and_wait(5);
		t = (i % 2) == 0;
		run_cycle(1'b0, 0, 1'b1, 5, pred_ghr, t);
	end
	lookup_and_wait(5);
	check_value("pred_table", 32'(table_gshare), 32'(pred_table));
endtask

task automatic run_random_mix();
	logic [31:0] bits;
	logic        lv;
	int          lsel;
	logic        uv;
	int          usel;
	ghr_t        ughr;
	logic        ut;
	pend_sel.delete();
	pend_ghr.delete();
	for (int c = 0; c < RANDOM_CYCLES; c++) begin
		draw_bits(1, bits);
		lv = bits[0];
		draw_bits(4, bits);
		lsel = int'(bits[3:0]);
		uv = 1'b0;
		usel = 0;
		ughr = '0;
		ut = 1'b0;
		draw_bits(1, bits);
		if (bits[0] && pend_sel.size() > 0) begin
			uv = 1'b1;
			usel = pend_sel.pop_front();
			ughr = pend_ghr.pop_front();
			draw_bits(2, bits);
			if (bits[1:0] == 2'b00) begin
				draw_bits(1, bits);
				ut = bits[0];
			end else begin
				ut = bias_outcome(usel);
			end
		end
		run_cycle(lv, lsel, uv, usel, ughr, ut);
	end
	run_cycle(1'b0, 0, 1'b0, 0, '0, 1'b0);
	run_cycle(1'b0, 0, 1'b0, 0, '0, 1'b0);
endtask

initial begin
	clk = 1'b0;
	rst_n = 1'b0;
	lookup_valid = 1'b0;
	lookup_pc = '0;
	update_valid = 1'b0;
	update_pc = '0;
	update_ghr = '0;
	update_taken = 1'b0;
	lfsr = 16'd61;
	exp_valid = 1'b0;
	exp_taken = 1'b0;
	exp_table = table_local;
	exp_ghr = '0;
	exp_sel = 0;
	got_pred = 1'b0;
	model_reset();

	@(posedge clk);
	@(negedge clk);
	check_value("pred_valid", 32'd0, 32'(pred_valid));
	@(posedge clk);
	rst_n <= 1'b1;
	@(negedge clk);
	check_value("pred_valid", 32'd0, 32'(pred_valid));

	check_first_lookup();
	check_back_to_back();
	check_saturation();
	check_alternating();
	run_random_mix();

	$display("PASS: all tests");
	$finish;
end

endmodule : tb_tournament_predictor
